// ==== list.f ====
design/memPkg.sv
design/ctrlPkg.sv
design/cacheWay.sv
design/wayArbiter.sv
design/bankedMem.sv
design/cacheCtrl.sv
design/memSystem.sv
verif/memSystemTb.sv

// ==== verif/memSystemTb.sv ====
// memory system testbench: directed cache and memory tests against a shadow model
`default_nettype none
`timescale 1ns/1ps

module memSystemTb import memPkg::*; ();

	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic rstN;
	addrT Addr;
	wordT DataIn;
	logic Rd;
	logic Wr;
	wordT DataOut;
	logic Done;
	logic Stall;
	logic CacheHit;
	logic err;

	// expected contents of every written word, indexed by word address
	wordT shadow [0:32767];
	integer seed;
	int lastCycles;
	wordT lastData;
	logic lastHit;
	logic lastErr;

	memSystem memSystem_inst (
		.clk(clk),
		.rstN(rstN),
		.Addr(Addr),
		.DataIn(DataIn),
		.Rd(Rd),
		.Wr(Wr),
		.DataOut(DataOut),
		.Done(Done),
		.Stall(Stall),
		.CacheHit(CacheHit),
		.err(err)
	);

	always #20 clk = ~clk;

	function automatic logic [15:0] makeAddr(input logic [4:0] tag, input logic [7:0] index,
			input logic [2:0] offset);
		return {tag, index, offset};
	endfunction

	function automatic wordT randWord();
		return wordT'($random(seed));
	endfunction

	task automatic checkValue(input string testName, input string what,
			input logic [15:0] expVal, input logic [15:0] actVal);
		assert (actVal === expVal) else begin
			$display("MISMATCH %s %s expected %h actual %h", testName, what, expVal, actVal);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// holds the request as a level until Done, cycle 0 is the first cycle it is seen
	task automatic issueRequest(input string testName, input logic rd, input logic wr,
			input logic [15:0] a, input wordT d);
		int cycles;
		@(posedge clk);
		Addr <= a;
		DataIn <= d;
		Rd <= rd;
		Wr <= wr;
		cycles = 0;
		@(negedge clk);
		while (Done !== 1'b1) begin
			assert (cycles < TIMEOUT) else begin
				$display("%s timed out waiting for Done after %0d cycles", testName, cycles);
				$display("Simulation failed");
				$fatal(1);
			end
			// busy from the compare cycle until Done
			if (cycles > 0)
				checkValue(testName, "Stall", 16'd1, Stall);
			cycles++;
			@(negedge clk);
		end
		checkValue(testName, "Stall at Done", 16'd0, Stall);
		lastCycles = cycles;
		lastData = DataOut;
		lastHit = CacheHit;
		lastErr = err;
		@(posedge clk);
		Rd <= 1'b0;
		Wr <= 1'b0;
	endtask

	task automatic doRead(input string testName, input logic [15:0] a,
			input logic checkHit, input logic expHit);
		issueRequest(testName, 1'b1, 1'b0, a, '0);
		checkValue(testName, "read data", shadow[a[15:1]], lastData);
		checkValue(testName, "err", 16'd0, lastErr);
		if (checkHit)
			checkValue(testName, "CacheHit", expHit, lastHit);
	endtask

	task automatic doWrite(input string testName, input logic [15:0] a, input wordT d,
			input logic checkHit, input logic expHit);
		issueRequest(testName, 1'b0, 1'b1, a, d);
		shadow[a[15:1]] = d;
		checkValue(testName, "err", 16'd0, lastErr);
		if (checkHit)
			checkValue(testName, "CacheHit", expHit, lastHit);
	endtask

	task automatic writeMissReadHit();
		logic [15:0] a;
		a = makeAddr(5'd1, 8'h10, 3'd2);
		doWrite("writeMissReadHit", a, randWord(), 1'b1, 1'b0);
		doRead("writeMissReadHit", a, 1'b1, 1'b1);
		// read hit answers in the compare cycle
		checkValue("writeMissReadHit", "read hit latency", 16'd1, 16'(lastCycles));
	endtask

	task automatic bothWaysUsed();
		logic [15:0] a0;
		logic [15:0] a1;
		a0 = makeAddr(5'd2, 8'h20, 3'd4);
		a1 = makeAddr(5'd3, 8'h20, 3'd4);
		doWrite("bothWaysUsed", a0, randWord(), 1'b1, 1'b0);
		doWrite("bothWaysUsed", a1, randWord(), 1'b1, 1'b0);
		doRead("bothWaysUsed", a0, 1'b1, 1'b1);
		doRead("bothWaysUsed", a1, 1'b1, 1'b1);
	endtask

	task automatic dirtyEviction();
		// two more tags on a full set push out both dirty lines
		for (int t = 4; t <= 5; t++)
			doWrite("dirtyEviction", makeAddr(5'(t), 8'h20, 3'd4), randWord(), 1'b0, 1'b0);
		for (int t = 2; t <= 5; t++)
			doRead("dirtyEviction", makeAddr(5'(t), 8'h20, 3'd4), 1'b0, 1'b0);
	endtask

	task automatic lineRefill();
		for (int w = 0; w < LINE_WORDS; w++) begin
			doWrite("lineRefill", makeAddr(5'd6, 8'h40, 3'(2 * w)), randWord(), 1'b1, w != 0);
			if (w != 0)
				checkValue("lineRefill", "write hit latency", 16'd2, 16'(lastCycles));
		end
		// victim pointer alternates, so three new tags evict both old lines
		for (int t = 7; t <= 9; t++)
			doWrite("lineRefill", makeAddr(5'(t), 8'h40, 3'd0), randWord(), 1'b0, 1'b0);
		for (int w = 0; w < LINE_WORDS; w++)
			doRead("lineRefill", makeAddr(5'd6, 8'h40, 3'(2 * w)), 1'b0, 1'b0);
	endtask

	task automatic errorRequests();
		logic [15:0] a;
		a = makeAddr(5'd1, 8'h10, 3'd2);
		issueRequest("errorRequests", 1'b1, 1'b1, a, randWord());
		checkValue("errorRequests", "err with Rd and Wr", 16'd1, lastErr);
		checkValue("errorRequests", "error latency", 16'd1, 16'(lastCycles));
		issueRequest("errorRequests", 1'b1, 1'b0, a | 16'd1, '0);
		checkValue("errorRequests", "err on odd address", 16'd1, lastErr);
		checkValue("errorRequests", "error latency", 16'd1, 16'(lastCycles));
		// neither request may have touched the cached line
		doRead("errorRequests", a, 1'b1, 1'b1);
	endtask

	initial begin
		seed = 32'hd82c6635;
		rstN <= 1'b0;
		Addr <= '0;
		DataIn <= '0;
		Rd <= 1'b0;
		Wr <= 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkValue("reset", "Done", 16'd0, Done);
		checkValue("reset", "Stall", 16'd0, Stall);
		checkValue("reset", "err", 16'd0, err);
		checkValue("reset", "CacheHit", 16'd0, CacheHit);
		writeMissReadHit();
		bothWaysUsed();
		dirtyEviction();
		lineRefill();
		errorRequests();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/memSystem.sv ====
// memory system top: controller, cache ways, way arbiter and banked memory
`default_nettype none
`timescale 1ns/1ps

module memSystem import memPkg::*, ctrlPkg::*; (
	input wire clk,
	input wire rstN,
	input wire addrT Addr,
	input wire wordT DataIn,
	input wire Rd,
	input wire Wr,
	output wordT DataOut,
	output logic Done,
	output logic Stall,
	output logic CacheHit,
	output logic err
);

	wayCmdT wayCmd;
	memCmdT memCmd;
	wayRespT resps [NUM_WAYS];
	logic anyHit;
	wordT hitData;
	logic [NUM_WAYS-1:0] victimSel;
	logic victimDirty;
	logic [TAG_W-1:0] victimTag;
	wordT victimData;
	logic advance;
	wordT rdData;
	logic rdValid;
	logic memErr;
	logic ctrlErr;

	// bank conflicts surface immediately as well as at the end of the miss
	assign err = ctrlErr || memErr;

	cacheCtrl uCtrl (
		.clk(clk),
		.rstN(rstN),
		.Addr(Addr),
		.DataIn(DataIn),
		.Rd(Rd),
		.Wr(Wr),
		.anyHit(anyHit),
		.hitData(hitData),
		.victimSel(victimSel),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimData(victimData),
		.rdData(rdData),
		.rdValid(rdValid),
		.memErr(memErr),
		.wayCmd(wayCmd),
		.memCmd(memCmd),
		.advance(advance),
		.DataOut(DataOut),
		.Done(Done),
		.Stall(Stall),
		.CacheHit(CacheHit),
		.err(ctrlErr)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : genWay
		cacheWay #(.WAY(w)) uWay (
			.clk(clk),
			.rstN(rstN),
			.cmd(wayCmd),
			.resp(resps[w])
		);
	end

	wayArbiter uArb (
		.clk(clk),
		.rstN(rstN),
		.resps(resps),
		.advance(advance),
		.anyHit(anyHit),
		.hitData(hitData),
		.victimSel(victimSel),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimData(victimData)
	);

	bankedMem uMem (
		.clk(clk),
		.rstN(rstN),
		.cmd(memCmd),
		.rdData(rdData),
		.rdValid(rdValid),
		.memErr(memErr)
	);

endmodule

`default_nettype wire

// ==== design/cacheCtrl.sv ====
// cache controller: request FSM for lookup, write-back, refill and completion
`default_nettype none
`timescale 1ns/1ps

module cacheCtrl import memPkg::*, ctrlPkg::*; (
	input wire clk,
	input wire rstN,
	input wire addrT Addr,
	input wire wordT DataIn,
	input wire Rd,
	input wire Wr,
	input wire anyHit,
	input wire wordT hitData,
	input wire [NUM_WAYS-1:0] victimSel,
	input wire victimDirty,
	input wire [TAG_W-1:0] victimTag,
	input wire wordT victimData,
	input wire wordT rdData,
	input wire rdValid,
	input wire memErr,
	output wayCmdT wayCmd,
	output memCmdT memCmd,
	output logic advance,
	output wordT DataOut,
	output logic Done,
	output logic Stall,
	output logic CacheHit,
	output logic err
);

	ctrlStateT state;
	ctrlStateT nextState;
	addrT reqAddr;
	wordT reqData;
	logic reqWr;
	logic memFault;
	logic [NUM_WAYS-1:0] vicSel;
	logic [TAG_W-1:0] vicTag;
	logic [OFFSET_W-2:0] reqCnt;
	logic [OFFSET_W-2:0] fillCnt;
	logic badReq;
	logic reqLast;
	logic fillLast;

	// conflicting strobes or an unaligned word address
	assign badReq = (Rd && Wr) || Addr.offset[0];
	assign reqLast = (reqCnt == (OFFSET_W-1)'(LINE_WORDS - 1));
	assign fillLast = (fillCnt == (OFFSET_W-1)'(LINE_WORDS - 1));

	always_comb begin
		nextState = state;
		wayCmd = '0;
		wayCmd.index = reqAddr.index;
		wayCmd.tag = reqAddr.tag;
		wayCmd.offset = reqAddr.offset;
		wayCmd.data = reqData;
		wayCmd.sel = vicSel;
		memCmd = '0;
		advance = 1'b0;
		DataOut = '0;
		Done = 1'b0;
		Stall = 1'b0;
		CacheHit = 1'b0;
		err = 1'b0;
		case (state)
			IDLE: begin
				if (Rd || Wr) begin
					nextState = badReq ? ERROR : COMPARE;
					advance = !badReq;
				end
			end
			COMPARE: begin
				wayCmd.lookup = 1'b1;
				if (anyHit && !reqWr) begin
					Done = 1'b1;
					CacheHit = 1'b1;
					DataOut = hitData;
					nextState = IDLE;
				end else if (anyHit) begin
					wayCmd.write = 1'b1;
					Stall = 1'b1;
					nextState = WRITE_HIT;
				end else begin
					Stall = 1'b1;
					nextState = victimDirty ? WB : FILL_REQ;
				end
			end
			WRITE_HIT: begin
				Done = 1'b1;
				CacheHit = 1'b1;
				nextState = IDLE;
			end
			WB: begin
				// victim line goes out one word per cycle
				Stall = 1'b1;
				wayCmd.offset = {reqCnt, 1'b0};
				memCmd.wr = 1'b1;
				memCmd.addr = '{tag: vicTag, index: reqAddr.index, offset: {reqCnt, 1'b0}};
				memCmd.data = victimData;
				if (reqLast)
					nextState = FILL_REQ;
			end
			FILL_REQ: begin
				Stall = 1'b1;
				memCmd.rd = 1'b1;
				memCmd.addr = '{tag: reqAddr.tag, index: reqAddr.index, offset: {reqCnt, 1'b0}};
				if (reqLast)
					nextState = FILL_DRAIN;
			end
			FILL_DRAIN: begin
				Stall = 1'b1;
				if (rdValid && fillLast)
					nextState = reqWr ? FILL_WRITE : DONE_WAIT;
			end
			FILL_WRITE: begin
				Stall = 1'b1;
				wayCmd.lookup = 1'b1;
				wayCmd.write = 1'b1;
				nextState = DONE_WAIT;
			end
			DONE_WAIT: begin
				wayCmd.lookup = 1'b1;
				Done = 1'b1;
				err = memFault;
				DataOut = reqWr ? '0 : hitData;
				nextState = IDLE;
			end
			ERROR: begin
				Done = 1'b1;
				err = 1'b1;
				nextState = IDLE;
			end
			default: nextState = IDLE;
		endcase
		// returning words go straight into the chosen way
		if (rdValid && (state == FILL_REQ || state == FILL_DRAIN)) begin
			wayCmd.fill = 1'b1;
			wayCmd.offset = {fillCnt, 1'b0};
			wayCmd.data = rdData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			reqWr <= 1'b0;
			memFault <= 1'b0;
			vicSel <= '0;
			reqCnt <= '0;
			fillCnt <= '0;
		end else begin
			state <= nextState;
			if (state == IDLE) begin
				reqWr <= Wr;
				memFault <= 1'b0;
			end else if (memErr) begin
				memFault <= 1'b1;
			end
			// victim is frozen here for the rest of the miss
			if (state == COMPARE) begin
				vicSel <= victimSel;
				reqCnt <= '0;
				fillCnt <= '0;
			end
			if (state == WB || state == FILL_REQ)
				reqCnt <= reqCnt + 1'b1;
			if (wayCmd.fill)
				fillCnt <= fillCnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			reqAddr <= Addr;
			reqData <= DataIn;
		end
		if (state == COMPARE)
			vicTag <= victimTag;
	end

	// the drain count relies on every refill read coming back on time
	assert property (@(posedge clk) disable iff (!rstN) memCmd.rd |-> ##MEM_LAT rdValid)
		else $error("refill read data did not return after MEM_LAT cycles");

endmodule

`default_nettype wire

// ==== design/bankedMem.sv ====
// banked main memory: four word-interleaved banks, pipelined reads, bank conflict check
`default_nettype none
`timescale 1ns/1ps

module bankedMem import memPkg::*, ctrlPkg::*; (
	input wire clk,
	input wire rstN,
	input wire memCmdT cmd,
	output wordT rdData,
	output logic rdValid,
	output logic memErr
);

	wordT memArr [NUM_BANKS][BANK_DEPTH];
	logic [BANK_W-1:0] bankSel;
	logic [BANK_W-1:0] rdBank;
	logic [ROW_W-1:0] rowSel;
	logic [ROW_W-1:0] rdRow;
	logic [NUM_BANKS-1:0] busy;
	logic access;
	logic rdPend;

	// low word-address bits pick the bank, the rest the row
	assign bankSel = cmd.addr[BANK_W:1];
	assign rowSel = cmd.addr[$bits(addrT)-1:BANK_W+1];
	assign access = cmd.rd || cmd.wr;
	assign memErr = access && busy[bankSel];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= '0;
			rdPend <= 1'b0;
			rdValid <= 1'b0;
		end else begin
			busy <= access ? (NUM_BANKS'(1) << bankSel) : '0;
			rdPend <= cmd.rd;
			rdValid <= rdPend;
		end
	end

	// stage one holds the address, stage two the array output
	always_ff @(posedge clk) begin
		if (cmd.wr)
			memArr[bankSel][rowSel] <= cmd.data;
		if (cmd.rd) begin
			rdBank <= bankSel;
			rdRow <= rowSel;
		end
		rdData <= memArr[rdBank][rdRow];
	end

	assert property (@(posedge clk) disable iff (!rstN) !(cmd.rd && cmd.wr))
		else $error("memory got rd and wr together");

endmodule

`default_nettype wire

// ==== design/wayArbiter.sv ====
// way arbiter: merges way responses into hit data and picks a replacement victim
`default_nettype none
`timescale 1ns/1ps

module wayArbiter import memPkg::*, ctrlPkg::*; (
	input wire clk,
	input wire rstN,
	input wire wayRespT resps [NUM_WAYS],
	input wire advance,
	output logic anyHit,
	output wordT hitData,
	output logic [NUM_WAYS-1:0] victimSel,
	output logic victimDirty,
	output logic [TAG_W-1:0] victimTag,
	output wordT victimData
);

	logic [WAY_W-1:0] victimPtr;
	logic [WAY_W-1:0] victimIdx;
	logic [NUM_WAYS-1:0] hitVec;
	logic foundFree;

	// round-robin pointer, moves once per accepted request
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			victimPtr <= '0;
		else if (advance)
			victimPtr <= (victimPtr == WAY_W'(NUM_WAYS - 1)) ? '0 : victimPtr + 1'b1;
	end

	always_comb begin
		anyHit = 1'b0;
		hitData = '0;
		hitVec = '0;
		foundFree = 1'b0;
		victimIdx = victimPtr;
		for (int i = 0; i < NUM_WAYS; i++) begin
			hitVec[i] = resps[i].hit;
			if (resps[i].hit) begin
				anyHit = 1'b1;
				hitData = resps[i].data;
			end
			// an empty way always wins over the pointer
			if (!resps[i].valid && !foundFree) begin
				foundFree = 1'b1;
				victimIdx = WAY_W'(i);
			end
		end
		victimSel = '0;
		victimSel[victimIdx] = 1'b1;
		victimDirty = resps[victimIdx].valid && resps[victimIdx].dirty;
		victimTag = resps[victimIdx].tagOut;
		victimData = resps[victimIdx].data;
	end

	assert property (@(posedge clk) disable iff (!rstN) $onehot0(hitVec))
		else $error("more than one way hit on the same set");

endmodule

`default_nettype wire

// ==== design/cacheWay.sv ====
// cache way: tag, valid, dirty and line storage for one way with tag compare
`default_nettype none
`timescale 1ns/1ps

module cacheWay import memPkg::*, ctrlPkg::*; #(
	parameter int WAY = 0
) (
	input wire clk,
	input wire rstN,
	input wire wayCmdT cmd,
	output wayRespT resp
);

	logic [TAG_W-1:0] tagArr [NUM_SETS];
	wordT dataArr [NUM_SETS][LINE_WORDS];
	logic [NUM_SETS-1:0] validBits;
	logic [NUM_SETS-1:0] dirtyBits;
	logic [OFFSET_W-2:0] wordSel;
	logic tagMatch;
	logic doWrite;
	logic doFill;
	logic lastWord;

	// word within the line, byte bit dropped
	assign wordSel = cmd.offset[OFFSET_W-1:1];
	assign tagMatch = validBits[cmd.index] && (tagArr[cmd.index] == cmd.tag);
	assign doWrite = cmd.write && cmd.lookup && tagMatch;
	assign doFill = cmd.fill && cmd.sel[WAY];
	assign lastWord = (wordSel == (OFFSET_W-1)'(LINE_WORDS - 1));

	always_comb begin
		resp.hit = cmd.lookup && tagMatch;
		resp.valid = validBits[cmd.index];
		resp.dirty = dirtyBits[cmd.index];
		resp.tagOut = tagArr[cmd.index];
		resp.data = dataArr[cmd.index][wordSel];
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (doWrite) begin
			dirtyBits[cmd.index] <= 1'b1;
		end else if (doFill) begin
			dirtyBits[cmd.index] <= 1'b0;
			// line only becomes visible once the last word is in
			if (lastWord)
				validBits[cmd.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (doWrite || doFill)
			dataArr[cmd.index][wordSel] <= cmd.data;
		if (doFill && lastWord)
			tagArr[cmd.index] <= cmd.tag;
	end

	// controller must never ask for a store and a refill in the same cycle
	assert property (@(posedge clk) disable iff (!rstN) !(cmd.write && cmd.fill))
		else $error("way %0d got write and fill together", WAY);

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
// controller package: FSM state encoding and command structs to the ways and memory
`default_nettype none

package ctrlPkg;
	import memPkg::*;

	typedef enum logic [3:0] {
		IDLE,
		COMPARE,
		WRITE_HIT,
		WB,
		FILL_REQ,
		FILL_DRAIN,
		FILL_WRITE,
		DONE_WAIT,
		ERROR
	} ctrlStateT;

	// broadcast to every way, sel picks the target for fill
	typedef struct packed {
		logic lookup;
		logic write;
		logic fill;
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0] tag;
		logic [OFFSET_W-1:0] offset;
		wordT data;
		logic [NUM_WAYS-1:0] sel;
	} wayCmdT;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		logic [TAG_W-1:0] tagOut;
		wordT data;
	} wayRespT;

	typedef struct packed {
		logic rd;
		logic wr;
		addrT addr;
		wordT data;
	} memCmdT;

endpackage

`default_nettype wire

// ==== design/memPkg.sv ====
// memory package: address geometry, word type and main memory sizing
`default_nettype none

package memPkg;

	// byte address split into tag, set index and byte offset
	localparam int TAG_W = 5;
	localparam int INDEX_W = 8;
	localparam int OFFSET_W = 3;

	// cache organisation
	localparam int NUM_WAYS = 2;
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
	localparam int LINE_WORDS = 4;
	localparam int NUM_SETS = 2 ** INDEX_W;

	// main memory, banks interleaved on word address
	localparam int NUM_BANKS = 4;
	localparam int BANK_W = $clog2(NUM_BANKS);
	localparam int ROW_W = TAG_W + INDEX_W + OFFSET_W - 1 - BANK_W;
	localparam int BANK_DEPTH = 2 ** ROW_W;
	localparam int MEM_LAT = 2;

	typedef logic [15:0] wordT;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
	} addrT;

endpackage

`default_nettype wire
